//--- src/dma_address_gen.sv
`timescale 1ns/1ns
`default_nettype none

module dma_address_gen (
   input  wire dma_pkg::dma_state_t  state,
   input  wire dma_pkg::count_t      count,
   input  wire dma_pkg::byte_t       oam_page,
   input  wire dma_pkg::gdma_cfg_t   gdma_cfg,
   input  wire dma_pkg::byte_t       rd_data,
   output dma_pkg::mem_port_t        mem
);

   import dma_pkg::*;

   always_comb begin
      mem.rd_addr = '0;
      mem.wr_addr = '0;
      mem.we      = 1'b0;
      case (state)
         st_oam: begin
            mem.rd_addr = {oam_page, count[7:0]}; // offsets 00 to 9F of the page
            mem.wr_addr = {OAM_PAGE, count[7:0]};
            mem.we      = 1'b1;
         end
         st_gdma: begin
            mem.rd_addr = gdma_cfg.src_base + addr_t'(count);
            mem.wr_addr = gdma_cfg.dst_base + addr_t'(count);
            mem.we      = 1'b1;
         end
         default: ;
      endcase
   end

   assign mem.re      = (state != st_idle);
   assign mem.wr_data = rd_data; // zero latency read feeds the write directly

endmodule

`default_nettype wire

//--- src/dma_byte_counter.sv
`timescale 1ns/1ns
`default_nettype none

module dma_byte_counter (
   input  wire logic             I_CLK,
   input  wire logic             I_SYNC_RESET,
   input  wire logic             clear,
   input  wire dma_pkg::count_t  limit,
   input  wire logic             step,
   output dma_pkg::count_t       count,
   output logic                  last
);

   import dma_pkg::*;

   count_t limit_q;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         count   <= '0;
         limit_q <= '0;
      end else if (clear) begin
         count   <= '0;
         limit_q <= limit; // length of the copy being started
      end else if (step) begin
         count   <= count + count_t'(1);
      end
   end

   assign last = (count == limit_q - count_t'(1)); // final byte index

   // the sequencer must stop on last, never run past the limit
   a_no_overrun: assert property (
      @(posedge I_CLK) disable iff (I_SYNC_RESET)
      step |-> (count != limit_q)
   );

endmodule

`default_nettype wire

//--- src/dma_controller.sv
`timescale 1ns/1ns
`default_nettype none

module dma_controller (
   input  wire logic              I_CLK,
   input  wire logic              I_SYNC_RESET,
   input  wire dma_pkg::wb_req_t  wb_req,
   input  wire dma_pkg::byte_t    mem_rd_data,
   output dma_pkg::wb_rsp_t       wb_rsp,
   output dma_pkg::mem_port_t     mem,
   output logic                   halt_cpu
);

   import dma_pkg::*;

   logic       oam_start;
   logic       gdma_start;
   byte_t      oam_page;
   gdma_cfg_t  gdma_cfg;
   dma_state_t state;
   logic       busy_gdma;
   logic       clear;
   logic       step;
   logic       last;
   count_t     limit;
   count_t     count;

   assign busy_gdma = (state == st_gdma); // drives the HDMA5 status

   dma_regs u_regs (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .wb_req       (wb_req),
      .busy_gdma    (busy_gdma),
      .count        (count),
      .wb_rsp       (wb_rsp),
      .oam_start    (oam_start),
      .oam_page     (oam_page),
      .gdma_start   (gdma_start),
      .gdma_cfg     (gdma_cfg)
   );

   dma_sequencer u_sequencer (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .oam_start    (oam_start),
      .gdma_start   (gdma_start),
      .gdma_length  (gdma_cfg.length),
      .last         (last),
      .state        (state),
      .clear        (clear),
      .limit        (limit),
      .step         (step),
      .halt_cpu     (halt_cpu)
   );

   dma_byte_counter u_counter (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .clear        (clear),
      .limit        (limit),
      .step         (step),
      .count        (count),
      .last         (last)
   );

   dma_address_gen u_address_gen (
      .state        (state),
      .count        (count),
      .oam_page     (oam_page),
      .gdma_cfg     (gdma_cfg),
      .rd_data      (mem_rd_data),
      .mem          (mem)
   );

endmodule

`default_nettype wire

//--- src/dma_pkg.sv
`default_nettype none

package dma_pkg;

   typedef logic [15:0] addr_t;  // memory or register address
   typedef logic [7:0]  byte_t;  // one data byte
   typedef logic [11:0] count_t; // byte index or copy length, up to 2048

   // wishbone classic request from the bus master
   typedef struct packed {
      logic  cyc;
      logic  stb;
      logic  we;
      addr_t adr;
      byte_t dat;
   } wb_req_t;

   // wishbone classic response back to the master
   typedef struct packed {
      logic  ack;
      byte_t dat;
   } wb_rsp_t;

   // zero latency memory port, one byte per cycle
   typedef struct packed {
      addr_t rd_addr;
      addr_t wr_addr;
      logic  re;
      logic  we;
      byte_t wr_data;
   } mem_port_t;

   // general copy setup formed from HDMA1 to HDMA5
   typedef struct packed {
      addr_t  src_base;
      addr_t  dst_base;
      count_t length;
   } gdma_cfg_t;

   typedef enum logic [1:0] {
      st_idle,
      st_oam,
      st_gdma
   } dma_state_t;

   localparam addr_t DMA_ADDR   = 16'hFF46; // OAM copy source page
   localparam addr_t HDMA1_ADDR = 16'hFF51; // source high
   localparam addr_t HDMA2_ADDR = 16'hFF52; // source low
   localparam addr_t HDMA3_ADDR = 16'hFF53; // destination high
   localparam addr_t HDMA4_ADDR = 16'hFF54; // destination low
   localparam addr_t HDMA5_ADDR = 16'hFF55; // length, start and status

   localparam byte_t  OAM_PAGE      = 8'hFE;    // object attribute memory page
   localparam count_t OAM_LENGTH    = 12'd160;  // 40 sprites of 4 bytes
   localparam addr_t  GDMA_DEST_TOP = 16'h8000; // video ram base
   localparam count_t BLOCK_BYTES   = 12'd16;   // general copy granule

endpackage

`default_nettype wire

//--- src/dma_regs.sv
`timescale 1ns/1ns
`default_nettype none

module dma_regs (
   input  wire logic                I_CLK,
   input  wire logic                I_SYNC_RESET,
   input  wire dma_pkg::wb_req_t    wb_req,
   input  wire logic                busy_gdma,
   input  wire dma_pkg::count_t     count,
   output dma_pkg::wb_rsp_t         wb_rsp,
   output logic                     oam_start,
   output dma_pkg::byte_t           oam_page,
   output logic                     gdma_start,
   output dma_pkg::gdma_cfg_t       gdma_cfg
);

   import dma_pkg::*;

   logic   ack_q;
   byte_t  rd_q;
   byte_t  rd_value;
   byte_t  dma_q;
   byte_t  hdma1_q;
   byte_t  hdma2_q;
   byte_t  hdma3_q;
   byte_t  hdma4_q;
   byte_t  hdma5_q;
   byte_t  status;
   count_t remaining;
   count_t blocks;
   logic   access;
   logic   wr_en;
   logic   oam_hit;
   logic   gdma_hit;
   logic   oam_hit_q;
   logic   gdma_hit_q;

   assign access = wb_req.cyc && wb_req.stb && !ack_q; // ack lands one cycle after stb
   assign wr_en  = access && wb_req.we;

   assign oam_hit  = wr_en && (wb_req.adr == DMA_ADDR);
   // bit 7 set would ask for the hblank mode, which is not supported
   assign gdma_hit = wr_en && (wb_req.adr == HDMA5_ADDR) && !wb_req.dat[7] && !busy_gdma;

   // bytes left after the current one, counted in whole blocks
   assign remaining = gdma_cfg.length - count_t'(1) - count;
   assign blocks    = remaining / BLOCK_BYTES;
   assign status    = busy_gdma ? {1'b0, blocks[6:0]} : 8'hFF;

   always_comb begin
      case (wb_req.adr)
         DMA_ADDR:   rd_value = dma_q;
         HDMA1_ADDR: rd_value = hdma1_q;
         HDMA2_ADDR: rd_value = hdma2_q;
         HDMA3_ADDR: rd_value = hdma3_q;
         HDMA4_ADDR: rd_value = hdma4_q;
         HDMA5_ADDR: rd_value = status;
         default:    rd_value = 8'hFF; // unmapped space floats high
      endcase
   end

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         ack_q      <= 1'b0;
         oam_hit_q  <= 1'b0;
         gdma_hit_q <= 1'b0;
         oam_start  <= 1'b0;
         gdma_start <= 1'b0;
         dma_q      <= '0;
         hdma1_q    <= '0;
         hdma2_q    <= '0;
         hdma3_q    <= '0;
         hdma4_q    <= '0;
         hdma5_q    <= '0;
      end else begin
         ack_q      <= access;
         oam_hit_q  <= oam_hit;
         gdma_hit_q <= gdma_hit;
         oam_start  <= oam_hit_q;  // second stage gives the start two edges after stb
         gdma_start <= gdma_hit_q;
         if (wr_en) begin
            case (wb_req.adr)
               DMA_ADDR:   dma_q   <= wb_req.dat;
               HDMA1_ADDR: hdma1_q <= wb_req.dat;
               HDMA2_ADDR: hdma2_q <= wb_req.dat;
               HDMA3_ADDR: hdma3_q <= wb_req.dat;
               HDMA4_ADDR: hdma4_q <= wb_req.dat;
               default:    ;
            endcase
         end
         if (gdma_hit) begin
            hdma5_q <= wb_req.dat; // only accepted starts change the length
         end
      end
   end

   always_ff @(posedge I_CLK) begin
      if (access) begin
         rd_q <= rd_value;
      end
   end

   assign wb_rsp.ack = ack_q;
   assign wb_rsp.dat = rd_q;

   assign oam_page = dma_q;

   assign gdma_cfg.src_base = {hdma1_q, hdma2_q[7:4], 4'h0};
   assign gdma_cfg.dst_base = GDMA_DEST_TOP + addr_t'({hdma3_q[4:0], hdma4_q[7:4], 4'h0});
   assign gdma_cfg.length   = (count_t'(hdma5_q[6:0]) + count_t'(1)) * BLOCK_BYTES;

   // a held request must not be acknowledged twice
   a_single_ack: assert property (
      @(posedge I_CLK) disable iff (I_SYNC_RESET)
      wb_rsp.ack |=> !wb_rsp.ack
   );

endmodule

`default_nettype wire

//--- src/dma_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module dma_sequencer (
   input  wire logic             I_CLK,
   input  wire logic             I_SYNC_RESET,
   input  wire logic             oam_start,
   input  wire logic             gdma_start,
   input  wire dma_pkg::count_t  gdma_length,
   input  wire logic             last,
   output dma_pkg::dma_state_t   state,
   output logic                  clear,
   output dma_pkg::count_t       limit,
   output logic                  step,
   output logic                  halt_cpu
);

   import dma_pkg::*;

   dma_state_t state_d;
   logic       idle;
   logic       start;

   assign idle  = (state == st_idle);
   assign start = oam_start || gdma_start;

   // only one engine at a time, starts outside idle are dropped
   always_comb begin
      state_d = state;
      case (state)
         st_idle: begin
            if (oam_start) begin
               state_d = st_oam; // OAM wins a tie
            end else if (gdma_start) begin
               state_d = st_gdma;
            end
         end
         st_oam, st_gdma: begin
            if (last) begin
               state_d = st_idle;
            end
         end
         default: state_d = st_idle;
      endcase
   end

   assign clear = idle && start;                        // count restarts at zero
   assign limit = oam_start ? OAM_LENGTH : gdma_length;
   assign step  = !idle;                                // one byte per active cycle

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         state    <= st_idle;
         halt_cpu <= 1'b0;
      end else begin
         state    <= state_d;
         halt_cpu <= (state_d == st_gdma); // cpu stalls for the whole general copy
      end
   end

   // the counter reaches its final byte only inside a running copy
   a_last_only_busy: assert property (
      @(posedge I_CLK) disable iff (I_SYNC_RESET)
      idle |-> !last
   );

endmodule

`default_nettype wire

//--- verification/dma_controller_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dma_controller_tb;

   import dma_pkg::*;

   localparam int ACK_TIMEOUT  = 16;   // bus cycles allowed for one ack
   localparam int COPY_TIMEOUT = 2200; // longest copy is 2048 bytes
   // all copies add up to under 2700 bytes, the rest is bus traffic and margin
   localparam int WATCHDOG_CYCLES = 12000;

   logic        clk;
   logic        sync_reset;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   mem_port_t   mem;
   byte_t       mem_rd_data;
   logic        halt_cpu;
   logic [31:0] lfsr_state;
   addr_t       wr_addr_log[$];
   byte_t       wr_data_log[$];
   logic        wr_halt_log[$];
   addr_t       rd_addr_log[$];
   logic        rd_en_log[$];
   int          errors;
   int          tests_run;
   int          tests_failed;

   tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(10)) u_clock_gen (
      .clk        (clk),
      .sync_reset (sync_reset)
   );

   dma_controller dut (
      .I_CLK        (clk),
      .I_SYNC_RESET (sync_reset),
      .wb_req       (wb_req),
      .mem_rd_data  (mem_rd_data),
      .wb_rsp       (wb_rsp),
      .mem          (mem),
      .halt_cpu     (halt_cpu)
   );

   // memory content, every byte depends on both address bytes
   function automatic byte_t model_byte(input addr_t adr);
      return adr[7:0] ^ adr[15:8] ^ 8'h5A;
   endfunction

   assign mem_rd_data = model_byte(mem.rd_addr); // zero latency read

   // write monitor, sampled mid cycle where the port is stable
   always @(negedge clk) begin
      if (!sync_reset && mem.we) begin
         wr_addr_log.push_back(mem.wr_addr);
         wr_data_log.push_back(mem.wr_data);
         wr_halt_log.push_back(halt_cpu);
         rd_addr_log.push_back(mem.rd_addr);
         rd_en_log.push_back(mem.re);
      end
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // taps 32 22 2 1
      return {s[30:0], fb};
   endfunction

   function automatic logic [31:0] random_bits(input int nbits);
      logic [31:0] value;
      int          i;
      value = '0;
      for (i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_step(lfsr_state); // one step per bit taken
         value      = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   task automatic wb_access(input logic we, input addr_t adr, input byte_t dat,
                            output byte_t rdata);
      int waited;
      waited = 0;
      rdata  = 8'h00;
      @(posedge clk);
      wb_req <= {1'b1, 1'b1, we, adr, dat}; // cyc, stb, we, adr, dat
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
      if (wb_rsp.ack) begin
         rdata = wb_rsp.dat;
      end else begin
         $display("no ack from register %h within %0d cycles", adr, ACK_TIMEOUT);
         errors++;
      end
      @(posedge clk);
      wb_req <= '0; // stb drops in the cycle after ack
   endtask

   task automatic wb_write(input addr_t adr, input byte_t dat);
      byte_t unused;
      wb_access(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input addr_t adr, output byte_t rdata);
      wb_access(1'b0, adr, 8'h00, rdata);
   endtask

   task automatic clear_log();
      wr_addr_log.delete();
      wr_data_log.delete();
      wr_halt_log.delete();
      rd_addr_log.delete();
      rd_en_log.delete();
   endtask

   // waits for the write strobe to rise and then to fall again
   task automatic wait_copy_done();
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!mem.we && waited < ACK_TIMEOUT);
      if (!mem.we) begin
         $display("copy did not start within %0d cycles", ACK_TIMEOUT);
         errors++;
      end
      waited = 0;
      while (mem.we && waited < COPY_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (mem.we) begin
         $display("copy still running after %0d cycles", COPY_TIMEOUT);
         errors++;
      end
   endtask

   task automatic check_writes(input addr_t src, input addr_t dst, input int length,
                               input logic halt_exp);
      int    i;
      addr_t src_addr;
      addr_t dst_addr;
      if (wr_addr_log.size() != length) begin
         $display("ERR mem.we cycles got %h expected %h", wr_addr_log.size(), length);
         errors++;
      end
      for (i = 0; i < wr_addr_log.size() && i < length; i++) begin
         src_addr = src + addr_t'(i);
         dst_addr = dst + addr_t'(i);
         if (rd_addr_log[i] !== src_addr) begin
            $display("ERR mem.rd_addr at byte %0d got %h expected %h", i, rd_addr_log[i],
                     src_addr);
            errors++;
         end
         if (rd_en_log[i] !== 1'b1) begin
            $display("ERR mem.re at byte %0d got %h expected 1", i, rd_en_log[i]);
            errors++;
         end
         if (wr_addr_log[i] !== dst_addr) begin
            $display("ERR mem.wr_addr at byte %0d got %h expected %h", i, wr_addr_log[i],
                     dst_addr);
            errors++;
         end
         if (wr_data_log[i] !== model_byte(src_addr)) begin
            $display("ERR mem.wr_data at byte %0d got %h expected %h", i, wr_data_log[i],
                     model_byte(src_addr));
            errors++;
         end
         if (wr_halt_log[i] !== halt_exp) begin
            $display("ERR halt_cpu at byte %0d got %h expected %h", i, wr_halt_log[i],
                     halt_exp);
            errors++;
         end
      end
   endtask

   task automatic program_bases(output addr_t src, output addr_t dst);
      byte_t hdma[4];
      int    i;
      for (i = 0; i < 4; i++) begin
         hdma[i] = byte_t'(random_bits(8));
         wb_write(addr_t'(HDMA1_ADDR + i), hdma[i]);
      end
      src = {hdma[0], hdma[1][7:4], 4'h0};
      dst = 16'h8000 + {3'b000, hdma[2][4:0], hdma[3][7:4], 4'h0}; // inside video ram
   endtask

   task automatic report_test(input string name, input int first_error);
      tests_run++;
      if (errors > first_error) begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - first_error);
      end else begin
         $display("test %s: ok", name);
      end
   endtask

   task automatic test_reset_readback();
      int    first_error;
      int    i;
      byte_t values[4];
      byte_t rdata;
      first_error = errors;
      if (wb_rsp.ack || mem.re || mem.we || halt_cpu) begin
         $display("ERR {wb_rsp.ack, mem.re, mem.we, halt_cpu} got %h expected 0",
                  {wb_rsp.ack, mem.re, mem.we, halt_cpu});
         errors++;
      end
      for (i = 0; i < 4; i++) begin
         values[i] = byte_t'(random_bits(8));
         wb_write(addr_t'(HDMA1_ADDR + i), values[i]);
      end
      for (i = 0; i < 4; i++) begin
         wb_read(addr_t'(HDMA1_ADDR + i), rdata);
         if (rdata !== values[i]) begin
            $display("ERR wb_rsp.dat of HDMA%0d got %h expected %h", i + 1, rdata, values[i]);
            errors++;
         end
      end
      wb_read(16'hFF50, rdata); // nothing mapped here
      if (rdata !== 8'hFF) begin
         $display("ERR wb_rsp.dat of unmapped FF50 got %h expected ff", rdata);
         errors++;
      end
      wb_read(HDMA5_ADDR, rdata);
      if (rdata !== 8'hFF) begin
         $display("ERR wb_rsp.dat of HDMA5 got %h expected ff", rdata);
         errors++;
      end
      report_test("reset and register readback", first_error);
   endtask

   task automatic test_oam_copy();
      int    first_error;
      byte_t page;
      first_error = errors;
      page        = byte_t'(random_bits(8));
      clear_log();
      wb_write(DMA_ADDR, page);
      wait_copy_done();
      check_writes({page, 8'h00}, 16'hFE00, 160, 1'b0);
      report_test("oam copy", first_error);
   endtask

   task automatic test_general_copy();
      int    first_error;
      addr_t src;
      addr_t dst;
      byte_t n;
      byte_t rdata;
      first_error = errors;
      program_bases(src, dst);
      n = byte_t'(random_bits(3));
      clear_log();
      wb_write(HDMA5_ADDR, n); // bit 7 clear asks for a general copy
      wait_copy_done();
      if (halt_cpu) begin
         $display("ERR halt_cpu after copy got 1 expected 0");
         errors++;
      end
      check_writes(src, dst, 16 * (n + 1), 1'b1);
      wb_read(HDMA5_ADDR, rdata);
      if (rdata !== 8'hFF) begin
         $display("ERR wb_rsp.dat of HDMA5 after copy got %h expected ff", rdata);
         errors++;
      end
      report_test("general copy", first_error);
   endtask

   task automatic test_status_running();
      int    first_error;
      addr_t src;
      addr_t dst;
      byte_t rdata;
      first_error = errors;
      program_bases(src, dst);
      clear_log();
      wb_write(HDMA5_ADDR, 8'h7F); // 128 blocks, the longest copy
      wb_read(HDMA5_ADDR, rdata);
      if (rdata[7] !== 1'b0) begin
         $display("ERR wb_rsp.dat bit 7 of HDMA5 while running got %h expected 0", rdata[7]);
         errors++;
      end
      if (!halt_cpu) begin
         $display("halt_cpu was low while the general copy was running");
         errors++;
      end
      wait_copy_done();
      check_writes(src, dst, 2048, 1'b1);
      report_test("status while running", first_error);
   endtask

   task automatic test_ignored_requests();
      int    first_error;
      addr_t src;
      addr_t dst;
      byte_t n;
      first_error = errors;
      program_bases(src, dst);
      clear_log();
      wb_write(HDMA5_ADDR, 8'h80 | byte_t'(random_bits(7))); // hblank mode is not built
      repeat (40) @(negedge clk);
      if (wr_addr_log.size() != 0 || halt_cpu) begin
         $display("ERR mem.we cycles after HDMA5 bit 7 write got %h expected 0",
                  wr_addr_log.size());
         errors++;
      end
      n = byte_t'(random_bits(3));
      clear_log();
      wb_write(HDMA5_ADDR, n);
      wb_write(DMA_ADDR, byte_t'(random_bits(8))); // lands while the general copy runs
      wait_copy_done();
      repeat (200) @(negedge clk); // longer than an OAM copy would take
      check_writes(src, dst, 16 * (n + 1), 1'b1);
      report_test("ignored requests", first_error);
   endtask

   initial begin
      lfsr_state   = 32'h5703db05;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      wb_req       = '0;
      @(negedge clk);
      while (sync_reset) @(negedge clk);
      test_reset_readback();
      test_oam_copy();
      test_general_copy();
      test_status_running();
      test_ignored_requests();
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic sync_reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      sync_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      sync_reset <= 1'b0; // released on a rising edge like any other input
   end

endmodule

`default_nettype wire

//--- vlog.f
src/dma_pkg.sv
src/dma_regs.sv
src/dma_byte_counter.sv
src/dma_sequencer.sv
src/dma_address_gen.sv
src/dma_controller.sv
verification/tb_clock_gen.sv
verification/dma_controller_tb.sv
